//--- tb.f
source/exu_pkg.sv
source/ex_stage_reg.sv
source/operand_forward.sv
source/int_alu.sv
source/branch_unit.sv
source/radix2_divider.sv
source/exu_top.sv
testbench/exu_chk.sv
testbench/tb_exu.sv

//--- run.sh
#!/usr/bin/env bash
# build tb_exu with Verilator from tb.f, run it, scan the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_exu -f tb.f -o sim_exu \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_exu > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log

grep -q "Simulation finished: FAIL" sim.log && { echo "result: fail"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "result: run did not complete"; exit 1; }
echo "result: pass"

//--- testbench/tb_exu.sv
`timescale 1ns/1ps

module tb_exu
    import exu_pkg::*;
();

    localparam int PERIOD     = 20;
    localparam int NUM_INSTR  = 200;
    localparam int TIMEOUT_NS = NUM_INSTR * (DIV_CYCLES + 10) * PERIOD;

    // one instruction in the model with its predicted outcome
    typedef struct packed {
        int        id;
        int        age;
        op_class_t cls;
        funct3_t   f3;
        logic      alt;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        xlen_t     pc;
        xlen_t     s1;
        xlen_t     s2;
        xlen_t     imm;
        xlen_t     exp_res;
        xlen_t     exp_npc;
        logic      redirect;
    } instr_t;

    logic      clk;
    logic      rst_n;
    logic      valid_in;
    xlen_t     pc_in;
    op_class_t op_class_in;
    funct3_t   funct3_in;
    logic      alt_in;
    reg_idx_t  rd_in;
    reg_idx_t  rs1_in;
    reg_idx_t  rs2_in;
    xlen_t     src1_in;
    xlen_t     src2_in;
    xlen_t     imm_in;
    logic      ready_mem;
    logic      mem_wr;
    reg_idx_t  mem_rd;
    xlen_t     mem_data;
    logic      wb_wr;
    reg_idx_t  wb_rd;
    xlen_t     wb_data;
    logic      branch_flush;
    logic      ready_id;
    logic      valid_out;
    reg_idx_t  rd_out;
    xlen_t     result;
    xlen_t     dnpc;
    logic      pc_update;

    integer    seed;
    int        n_accepted;
    int        n_done;
    int        n_flushed;
    int        err_count;
    logic      flushed_last;
    // holds at most the one instruction sitting in execute
    instr_t    model_q[$];

    exu_top u_dut (.*);

    always #(PERIOD / 2) clk = ~clk;

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // biased toward division corner values
    function automatic xlen_t rand_word();
        case (rand_below(8))
            0: return '0;
            1: return '1;
            2: return {1'b1, {(XLEN-1){1'b0}}};
            3: return xlen_t'(rand_below(16));
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    // MEM before WB and x0 never bypassed
    function automatic xlen_t fwd_value(input reg_idx_t idx, input xlen_t reg_val);
        if (idx == '0)
            return reg_val;
        if (mem_wr && (mem_rd == idx))
            return mem_data;
        if (wb_wr && (wb_rd == idx))
            return wb_data;
        return reg_val;
    endfunction

    // RISC-V M rules with funct3 bit 0 for unsigned and bit 1 for remainder
    function automatic xlen_t div_expect(input funct3_t f3, input xlen_t a, input xlen_t b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] sq;
        logic signed [XLEN-1:0] sr;
        xlen_t                  q;
        xlen_t                  r;
        sa = a;
        sb = b;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (!f3[0] && (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1)) begin
            // signed overflow
            q = a;
            r = '0;
        end else if (!f3[0]) begin
            sq = sa / sb;
            sr = sa % sb;
            q  = sq;
            r  = sr;
        end else begin
            q = a / b;
            r = a % b;
        end
        return f3[1] ? r : q;
    endfunction

    function automatic xlen_t alu_expect(input instr_t e, input xlen_t a, input xlen_t b);
        xlen_t                  y;
        logic signed [XLEN-1:0] sa;
        sa = a;
        // second operand is the immediate for op_imm
        y  = (e.cls == CLS_OP_IMM) ? e.imm : b;
        case (e.cls)
            CLS_LUI:           return e.imm;
            CLS_AUIPC:         return e.pc + e.imm;
            CLS_JAL, CLS_JALR: return e.pc + xlen_t'(PC_STEP);
            CLS_BRANCH:        return a - b;
            CLS_DIV:           return div_expect(e.f3, a, b);
            default:           ;
        endcase
        case (e.f3)
            3'b000: return ((e.cls == CLS_OP_REG) && e.alt) ? a - y : a + y;
            3'b001: return a << y[5:0];
            3'b010: return xlen_t'($signed(a) < $signed(y));
            3'b011: return xlen_t'(a < y);
            3'b100: return a ^ y;
            3'b101: begin
                if (e.alt)
                    return sa >>> y[5:0];
                return a >> y[5:0];
            end
            3'b110: return a | y;
            default: return a & y;
        endcase
    endfunction

    // fills in result, next pc and redirect from the current bypass inputs
    function automatic instr_t predict(input instr_t e);
        xlen_t a;
        xlen_t b;
        logic  taken;
        a = fwd_value(e.rs1, e.s1);
        b = e.s2;
        if ((e.cls == CLS_BRANCH) || (e.cls == CLS_OP_REG) || (e.cls == CLS_DIV))
            b = fwd_value(e.rs2, e.s2);
        case (e.f3)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            3'b110:  taken = (a < b);
            3'b111:  taken = (a >= b);
            default: taken = 1'b0;
        endcase
        e.redirect = (e.cls == CLS_JAL) || (e.cls == CLS_JALR) ||
                     ((e.cls == CLS_BRANCH) && taken);
        if (e.cls == CLS_JALR)
            e.exp_npc = (a + e.imm) & ~xlen_t'(1);
        else if (e.redirect)
            e.exp_npc = e.pc + e.imm;
        else
            e.exp_npc = e.pc + xlen_t'(PC_STEP);
        e.exp_res = alu_expect(e, a, b);
        return e;
    endfunction

    task automatic drive_inputs();
        // MEM and WB stall together with ready_mem so the bypass holds
        if (ready_mem) begin
            mem_wr   = (rand_below(2) == 1);
            mem_rd   = reg_idx_t'(rand_below(4));
            mem_data = rand_word();
            wb_wr    = (rand_below(2) == 1);
            wb_rd    = reg_idx_t'(rand_below(4));
            wb_data  = rand_word();
        end
        // rare flush and downstream never takes in that cycle
        branch_flush = (rand_below(256) == 0);
        ready_mem    = !branch_flush && (rand_below(4) != 0);
        valid_in     = (n_accepted < NUM_INSTR) && (rand_below(8) != 0);
        case (rand_below(16))
            0:         op_class_in = CLS_LUI;
            1:         op_class_in = CLS_AUIPC;
            2:         op_class_in = CLS_JAL;
            3:         op_class_in = CLS_JALR;
            4, 5:      op_class_in = CLS_BRANCH;
            6, 7, 8:   op_class_in = CLS_OP_IMM;
            9, 10, 11: op_class_in = CLS_OP_REG;
            default:   op_class_in = CLS_DIV;
        endcase
        funct3_in = funct3_t'(rand_below(8));
        if (op_class_in == CLS_BRANCH) begin
            // skip the two unused encodings 010 and 011
            funct3_in = funct3_t'(rand_below(6));
            if (funct3_in >= 3'd2)
                funct3_in = funct3_in + 3'd2;
        end
        if (op_class_in == CLS_DIV)
            funct3_in[2] = 1'b1;
        alt_in  = (rand_below(2) == 1);
        rd_in   = reg_idx_t'(rand_below(32));
        // small index range so bypass hits are frequent
        rs1_in  = reg_idx_t'(rand_below(4));
        rs2_in  = reg_idx_t'(rand_below(4));
        pc_in   = rand_word() & ~xlen_t'(3);
        src1_in = rand_word();
        src2_in = rand_word();
        imm_in  = rand_word();
        // most negative over minus one on x0 sources so no bypass replaces them
        if ((op_class_in == CLS_DIV) && (rand_below(4) == 0)) begin
            rs1_in  = '0;
            rs2_in  = '0;
            src1_in = {1'b1, {(XLEN-1){1'b0}}};
            src2_in = '1;
        end
    endtask

    // runs just before the rising edge with outputs settled
    task automatic sample_and_update();
        instr_t    e;
        op_class_t cls;
        logic      present;
        logic      stall;
        logic      fire;
        int        errs_before;
        errs_before = err_count;
        present     = (model_q.size() != 0);
        stall       = 1'b0;
        fire        = 1'b0;
        e           = '0;
        if (present) begin
            e = model_q[0];
            // divider latches operands on the start edge only
            if ((e.cls != CLS_DIV) || (e.age == 0))
                e = predict(e);
            // start edge plus DIV_CYCLES iterations
            stall = (e.cls == CLS_DIV) && (e.age <= DIV_CYCLES);
            fire  = !stall && ready_mem;
        end
        check_bit("valid_out", valid_out, present && !stall);
        check_bit("ready_id", ready_id, ready_mem && !stall);
        check_bit("pc_update", pc_update, fire && e.redirect);
        cls = e.cls;
        if (fire) begin
            check_idx("rd_out", rd_out, e.rd);
            check_xlen("result", result, e.exp_res);
            check_xlen("dnpc", dnpc, e.exp_npc);
            $display("test %0d %s: %s", e.id, cls.name(),
                     (err_count == errs_before) ? "ok" : "mismatch");
            n_done++;
            void'(model_q.pop_front());
        end else if (branch_flush && present) begin
            $display("test %0d %s: flushed in execute", e.id, cls.name());
            n_flushed++;
            model_q.delete();
        end else if (present) begin
            e.age = e.age + 1;
            model_q[0] = e;
        end
        flushed_last = branch_flush;
        // stage loads whenever it reports ready
        if (!branch_flush && ready_mem && !stall && valid_in) begin
            e     = '0;
            e.id  = n_accepted;
            e.cls = op_class_in;
            e.f3  = funct3_in;
            e.alt = alt_in;
            e.rd  = rd_in;
            e.rs1 = rs1_in;
            e.rs2 = rs2_in;
            e.pc  = pc_in;
            e.s1  = src1_in;
            e.s2  = src2_in;
            e.imm = imm_in;
            model_q.push_back(e);
            n_accepted++;
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the instructions did not all complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        seed         = 32'h488b40b4;
        clk          = 1'b0;
        rst_n        = 1'b0;
        valid_in     = 1'b0;
        pc_in        = '0;
        op_class_in  = CLS_NONE;
        funct3_in    = '0;
        alt_in       = 1'b0;
        rd_in        = '0;
        rs1_in       = '0;
        rs2_in       = '0;
        src1_in      = '0;
        src2_in      = '0;
        imm_in       = '0;
        ready_mem    = 1'b0;
        mem_wr       = 1'b0;
        mem_rd       = '0;
        mem_data     = '0;
        wb_wr        = 1'b0;
        wb_rd        = '0;
        wb_data      = '0;
        branch_flush = 1'b0;
        n_accepted   = 0;
        n_done       = 0;
        n_flushed    = 0;
        err_count    = 0;
        flushed_last = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while ((n_accepted < NUM_INSTR) || (model_q.size() != 0)) begin
            drive_inputs();
            #(PERIOD / 4);
            sample_and_update();
            @(negedge clk);
            // nothing loads on a flush edge so the stage must be empty
            if (flushed_last)
                check_bit("valid_out", valid_out, 1'b0);
        end
        $display("tests %0d: completed %0d, flushed %0d, errors %0d",
                 n_accepted, n_done, n_flushed, err_count);
        if (err_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- testbench/exu_chk.sv
`timescale 1ns/1ps

module exu_chk
    import exu_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     ready_mem,
    input logic     branch_flush,
    input logic     valid_out,
    input logic     pc_update,
    input reg_idx_t rd_out,
    input xlen_t    result,
    input xlen_t    dnpc
);

    // redirect only with a valid instruction
    redirect_valid: assert property (@(posedge clk) disable iff (!rst_n)
        pc_update |-> valid_out)
        else $error("pc_update high while valid_out is low");

    // back-pressure holds the outputs, unless flushed
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_out && !ready_mem && !branch_flush) |=>
            ($stable(result) && $stable(dnpc) && $stable(rd_out)))
        else $error("result, dnpc or rd_out changed while held by ready_mem");

    reset_idle: assert property (@(posedge clk) !rst_n |=> !valid_out)
        else $error("valid_out high during reset");

endmodule

bind exu_top exu_chk u_chk (
    .clk(clk), .rst_n(rst_n), .ready_mem(ready_mem), .branch_flush(branch_flush),
    .valid_out(valid_out), .pc_update(pc_update), .rd_out(rd_out),
    .result(result), .dnpc(dnpc)
);

//--- source/exu_top.sv
`timescale 1ns/1ps

module exu_top
    import exu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      valid_in,
    input  xlen_t     pc_in,
    input  op_class_t op_class_in,
    input  funct3_t   funct3_in,
    input  logic      alt_in,
    input  reg_idx_t  rd_in,
    input  reg_idx_t  rs1_in,
    input  reg_idx_t  rs2_in,
    input  xlen_t     src1_in,
    input  xlen_t     src2_in,
    input  xlen_t     imm_in,
    input  logic      ready_mem,
    input  logic      mem_wr,
    input  reg_idx_t  mem_rd,
    input  xlen_t     mem_data,
    input  logic      wb_wr,
    input  reg_idx_t  wb_rd,
    input  xlen_t     wb_data,
    input  logic      branch_flush,
    output logic      ready_id,
    output logic      valid_out,
    output reg_idx_t  rd_out,
    output xlen_t     result,
    output xlen_t     dnpc,
    output logic      pc_update
);

    logic      ex_valid;
    xlen_t     ex_pc;
    op_class_t ex_class;
    funct3_t   ex_funct3;
    logic      ex_alt;
    reg_idx_t  ex_rd;
    reg_idx_t  ex_rs1;
    reg_idx_t  ex_rs2;
    xlen_t     ex_src1;
    xlen_t     ex_src2;
    xlen_t     ex_imm;
    xlen_t     src1;
    xlen_t     src2;
    xlen_t     alu_result;
    xlen_t     div_result;
    logic      div_done;
    logic      is_div;
    logic      stall;

    assign is_div = ex_valid && (ex_class == CLS_DIV);

    // divide still running blocks the stage
    assign stall     = is_div && !div_done;
    assign ready_id  = stall ? 1'b0 : ready_mem;
    assign valid_out = ex_valid && !stall;
    assign rd_out    = ex_rd;

    ex_stage_reg u_stage_reg (
        .clk(clk), .rst_n(rst_n), .load(ready_id), .flush(branch_flush),
        .valid_in(valid_in), .pc_in(pc_in), .op_class_in(op_class_in),
        .funct3_in(funct3_in), .alt_in(alt_in), .rd_in(rd_in),
        .rs1_in(rs1_in), .rs2_in(rs2_in), .src1_in(src1_in),
        .src2_in(src2_in), .imm_in(imm_in),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_class(ex_class),
        .ex_funct3(ex_funct3), .ex_alt(ex_alt), .ex_rd(ex_rd),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_src1(ex_src1),
        .ex_src2(ex_src2), .ex_imm(ex_imm)
    );

    operand_forward u_forward (
        .ex_class(ex_class), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
        .ex_src1(ex_src1), .ex_src2(ex_src2),
        .mem_wr(mem_wr), .wb_wr(wb_wr), .mem_rd(mem_rd), .wb_rd(wb_rd),
        .mem_data(mem_data), .wb_data(wb_data),
        .src1(src1), .src2(src2)
    );

    int_alu u_alu (
        .ex_class(ex_class), .ex_funct3(ex_funct3), .ex_alt(ex_alt),
        .ex_pc(ex_pc), .ex_imm(ex_imm), .src1(src1), .src2(src2),
        .alu_result(alu_result)
    );

    branch_unit u_branch (
        .ex_valid(ex_valid), .ready_mem(ready_mem), .ex_class(ex_class),
        .ex_funct3(ex_funct3), .ex_pc(ex_pc), .ex_imm(ex_imm),
        .src1(src1), .src2(src2), .dnpc(dnpc), .pc_update(pc_update)
    );

    // start is a level, divider only takes it when idle
    // any load or flush sends it back to idle
    radix2_divider u_divider (
        .clk(clk), .rst_n(rst_n), .start(is_div),
        .clear(ready_id || branch_flush),
        .is_signed(!ex_funct3[0]), .want_rem(ex_funct3[1]),
        .dividend(src1), .divisor(src2),
        .done(div_done), .div_result(div_result)
    );

    assign result = (ex_class == CLS_DIV) ? div_result : alu_result;

endmodule

//--- source/radix2_divider.sv
`timescale 1ns/1ps

module radix2_divider
    import exu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  clear,
    input  logic  is_signed,
    input  logic  want_rem,
    input  xlen_t dividend,
    input  xlen_t divisor,
    output logic  done,
    output xlen_t div_result
);

    div_state_t           state;
    logic [DIV_CNT_W-1:0] cnt;
    xlen_t                quo;
    xlen_t                rem;
    xlen_t                dsr;
    logic                 neg_quo;
    logic                 neg_rem;
    logic                 rem_sel;
    xlen_t                abs_a;
    xlen_t                abs_b;
    logic [XLEN:0]        trial;
    logic [XLEN:0]        diff;

    // magnitudes, signed ops only
    assign abs_a = (is_signed && dividend[XLEN-1]) ? -dividend : dividend;
    assign abs_b = (is_signed && divisor[XLEN-1]) ? -divisor : divisor;

    // shift next dividend bit into partial remainder
    assign trial = {rem, quo[XLEN-1]};
    assign diff  = trial - {1'b0, dsr};

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state <= DIV_RUN;
                        cnt   <= '0;
                    end
                end
                DIV_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DIV_CNT_W'(DIV_CYCLES - 1))
                        state <= DIV_DONE;
                end
                // done holds until clear
                default: state <= state;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == DIV_IDLE) && start) begin
            quo     <= abs_a;
            rem     <= '0;
            dsr     <= abs_b;
            rem_sel <= want_rem;
            // x/0 keeps quotient all ones, so no negate there
            neg_quo <= is_signed && (dividend[XLEN-1] ^ divisor[XLEN-1]) &&
                       (divisor != '0);
            // remainder takes the dividend sign
            neg_rem <= is_signed && dividend[XLEN-1];
        end else if (state == DIV_RUN) begin
            // restoring step
            if (!diff[XLEN]) begin
                rem <= diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end else begin
                rem <= trial[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end
    end

    assign done = (state == DIV_DONE);

    // sign fixup; overflow case falls out of the magnitude math
    assign div_result = rem_sel ? (neg_rem ? -rem : rem)
                                : (neg_quo ? -quo : quo);

endmodule

//--- source/branch_unit.sv
`timescale 1ns/1ps

module branch_unit
    import exu_pkg::*;
(
    input  logic      ex_valid,
    input  logic      ready_mem,
    input  op_class_t ex_class,
    input  funct3_t   ex_funct3,
    input  xlen_t     ex_pc,
    input  xlen_t     ex_imm,
    input  xlen_t     src1,
    input  xlen_t     src2,
    output xlen_t     dnpc,
    output logic      pc_update
);

    logic  is_eq;
    logic  is_lt;
    logic  is_ltu;
    logic  taken;
    logic  is_jump;
    xlen_t jalr_tgt;

    assign is_eq  = (src1 == src2);
    assign is_lt  = ($signed(src1) < $signed(src2));
    assign is_ltu = (src1 < src2);

    // branch condition from funct3
    always_comb begin
        case (ex_funct3)
            3'b000:  taken = is_eq;
            3'b001:  taken = !is_eq;
            3'b100:  taken = is_lt;
            3'b101:  taken = !is_lt;
            3'b110:  taken = is_ltu;
            3'b111:  taken = !is_ltu;
            // 010/011 not a branch
            default: taken = 1'b0;
        endcase
    end

    assign is_jump = (ex_class == CLS_JAL) || (ex_class == CLS_JALR);

    // jalr target with bit 0 dropped
    assign jalr_tgt = (src1 + ex_imm) & ~xlen_t'(1);

    always_comb begin
        if (ex_class == CLS_JALR)
            dnpc = jalr_tgt;
        else if ((ex_class == CLS_JAL) || ((ex_class == CLS_BRANCH) && taken))
            dnpc = ex_pc + ex_imm;
        else
            dnpc = ex_pc + xlen_t'(PC_STEP);
    end

    // redirect only once the instruction can leave
    assign pc_update = ex_valid && ready_mem &&
                       (is_jump || ((ex_class == CLS_BRANCH) && taken));

endmodule

//--- source/int_alu.sv
`timescale 1ns/1ps

module int_alu
    import exu_pkg::*;
(
    input  op_class_t ex_class,
    input  funct3_t   ex_funct3,
    input  logic      ex_alt,
    input  xlen_t     ex_pc,
    input  xlen_t     ex_imm,
    input  xlen_t     src1,
    input  xlen_t     src2,
    output xlen_t     alu_result
);

    xlen_t      op_a;
    xlen_t      op_b;
    logic [5:0] shamt;
    logic       do_sub;
    logic       use_funct;
    xlen_t      sum;

    // operand select per class
    always_comb begin
        op_a  = src1;
        op_b  = src2;
        shamt = src2[5:0];
        case (ex_class)
            CLS_LUI: begin
                op_a = '0;
                op_b = ex_imm;
            end
            CLS_AUIPC: begin
                op_a = ex_pc;
                op_b = ex_imm;
            end
            // link value pc + 4
            CLS_JAL, CLS_JALR: begin
                op_a = ex_pc;
                op_b = xlen_t'(PC_STEP);
            end
            CLS_OP_IMM: begin
                op_b  = ex_imm;
                shamt = ex_imm[5:0];
            end
            default: ;
        endcase
    end

    // sub for branches and op_reg with funct7 bit set
    assign do_sub    = (ex_class == CLS_BRANCH) ||
                       ((ex_class == CLS_OP_REG) && (ex_funct3 == 3'b000) && ex_alt);
    assign use_funct = (ex_class == CLS_OP_IMM) || (ex_class == CLS_OP_REG);

    // shared adder, two's complement subtract
    assign sum = op_a + (do_sub ? ~op_b : op_b) + xlen_t'(do_sub);

    always_comb begin
        if (!use_funct) begin
            // lui, auipc, links and branch compare all use the adder
            alu_result = sum;
        end else begin
            case (ex_funct3)
                3'b000: alu_result = sum;
                3'b001: alu_result = op_a << shamt;
                3'b010: alu_result = xlen_t'($signed(op_a) < $signed(op_b));
                3'b011: alu_result = xlen_t'(op_a < op_b);
                3'b100: alu_result = op_a ^ op_b;
                // alt picks arithmetic shift
                3'b101: alu_result = ex_alt ? xlen_t'($signed(op_a) >>> shamt)
                                            : (op_a >> shamt);
                3'b110: alu_result = op_a | op_b;
                default: alu_result = op_a & op_b;
            endcase
        end
    end

endmodule

//--- source/operand_forward.sv
`timescale 1ns/1ps

module operand_forward
    import exu_pkg::*;
(
    input  op_class_t ex_class,
    input  reg_idx_t  ex_rs1,
    input  reg_idx_t  ex_rs2,
    input  xlen_t     ex_src1,
    input  xlen_t     ex_src2,
    input  logic      mem_wr,
    input  logic      wb_wr,
    input  reg_idx_t  mem_rd,
    input  reg_idx_t  wb_rd,
    input  xlen_t     mem_data,
    input  xlen_t     wb_data,
    output xlen_t     src1,
    output xlen_t     src2
);

    logic use_rs2;
    logic mem_hit1;
    logic mem_hit2;
    logic wb_hit1;
    logic wb_hit2;

    // only these classes actually read rs2
    assign use_rs2 = (ex_class == CLS_BRANCH) || (ex_class == CLS_OP_REG) ||
                     (ex_class == CLS_DIV);

    // x0 never forwarded
    assign mem_hit1 = mem_wr && (ex_rs1 != '0) && (mem_rd == ex_rs1);
    assign wb_hit1  = wb_wr && (ex_rs1 != '0) && (wb_rd == ex_rs1);
    assign mem_hit2 = use_rs2 && mem_wr && (ex_rs2 != '0) && (mem_rd == ex_rs2);
    assign wb_hit2  = use_rs2 && wb_wr && (ex_rs2 != '0) && (wb_rd == ex_rs2);

    // younger producer (MEM) has priority over WB
    assign src1 = mem_hit1 ? mem_data : (wb_hit1 ? wb_data : ex_src1);
    assign src2 = mem_hit2 ? mem_data : (wb_hit2 ? wb_data : ex_src2);

endmodule

//--- source/ex_stage_reg.sv
`timescale 1ns/1ps

module ex_stage_reg
    import exu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load,
    input  logic      flush,
    input  logic      valid_in,
    input  xlen_t     pc_in,
    input  op_class_t op_class_in,
    input  funct3_t   funct3_in,
    input  logic      alt_in,
    input  reg_idx_t  rd_in,
    input  reg_idx_t  rs1_in,
    input  reg_idx_t  rs2_in,
    input  xlen_t     src1_in,
    input  xlen_t     src2_in,
    input  xlen_t     imm_in,
    output logic      ex_valid,
    output xlen_t     ex_pc,
    output op_class_t ex_class,
    output funct3_t   ex_funct3,
    output logic      ex_alt,
    output reg_idx_t  ex_rd,
    output reg_idx_t  ex_rs1,
    output reg_idx_t  ex_rs2,
    output xlen_t     ex_src1,
    output xlen_t     ex_src2,
    output xlen_t     ex_imm
);

    // control part, flush wins over a load in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ex_valid <= 1'b0;
            ex_class <= CLS_NONE;
        end else if (load) begin
            ex_valid <= valid_in;
            ex_class <= op_class_in;
        end
    end

    // payload, only meaningful while ex_valid
    always_ff @(posedge clk) begin
        if (load) begin
            ex_pc     <= pc_in;
            ex_funct3 <= funct3_in;
            ex_alt    <= alt_in;
            ex_rd     <= rd_in;
            ex_rs1    <= rs1_in;
            ex_rs2    <= rs2_in;
            // register file copies, may be stale
            ex_src1   <= src1_in;
            ex_src2   <= src2_in;
            ex_imm    <= imm_in;
        end
    end

endmodule

//--- source/exu_pkg.sv
package exu_pkg;

    // data path width
    localparam int XLEN = 64;

    // sequential fetch step
    localparam int PC_STEP = 4;

    // one quotient bit per iteration
    localparam int DIV_CYCLES = XLEN;

    // wide enough to count up to DIV_CYCLES
    localparam int DIV_CNT_W = 7;

    // data or address word
    typedef logic [XLEN-1:0] xlen_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // funct3 field of the instruction
    typedef logic [2:0] funct3_t;

    // instruction class, decoded in ID
    typedef enum logic [3:0] {
        CLS_NONE   = 4'd0,
        CLS_LUI    = 4'd1,
        CLS_AUIPC  = 4'd2,
        CLS_JAL    = 4'd3,
        CLS_JALR   = 4'd4,
        CLS_BRANCH = 4'd5,
        CLS_OP_IMM = 4'd6,
        CLS_OP_REG = 4'd7,
        CLS_DIV    = 4'd8
    } op_class_t;

    // divider FSM states
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_t;

endpackage
